// File: all.f
+incdir+hdl
hdl/core_pkg.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/core_top.sv
tests/core_checker.sv
tests/core_tb.sv

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module alu (
    input  core_pkg::alu_op_e     op_i,
    input  logic [`CORE_XLEN-1:0] a_i,
    input  logic [`CORE_XLEN-1:0] b_i,
    output logic [`CORE_XLEN-1:0] result_o,
    output logic                  br_taken_o
);

    logic [`CORE_XLEN-1:0] sum;
    logic [4:0]            shamt;
    logic                  lt_s;
    logic                  lt_u;
    logic                  eq;

    assign sum   = a_i + b_i;
    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign eq    = a_i == b_i;

    always_comb begin
        result_o   = '0;
        br_taken_o = 1'b0;
        case (op_i)
            core_pkg::ALU_ADD:  result_o = sum;
            core_pkg::ALU_SUB:  result_o = a_i - b_i;
            core_pkg::ALU_AND:  result_o = a_i & b_i;
            core_pkg::ALU_OR:   result_o = a_i | b_i;
            core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            core_pkg::ALU_SLL:  result_o = a_i << shamt;
            core_pkg::ALU_SRL:  result_o = a_i >> shamt;
            core_pkg::ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            core_pkg::ALU_SLT:  result_o = {{(`CORE_XLEN-1){1'b0}}, lt_s};
            core_pkg::ALU_SLTU: result_o = {{(`CORE_XLEN-1){1'b0}}, lt_u};
            core_pkg::ALU_JALR: result_o = {sum[`CORE_XLEN-1:1], 1'b0}; // lsb cleared
            // branch compares only raise the flag
            core_pkg::ALU_BEQ:  br_taken_o = eq;
            core_pkg::ALU_BNE:  br_taken_o = !eq;
            core_pkg::ALU_BLT:  br_taken_o = lt_s;
            core_pkg::ALU_BGE:  br_taken_o = !lt_s;
            core_pkg::ALU_BLTU: br_taken_o = lt_u;
            core_pkg::ALU_BGEU: br_taken_o = !lt_u;
            default: ;
        endcase
    end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct3, alu group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3, branch group
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub / sra

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

endpackage

// File: hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width
`define CORE_XLEN 32

// integer register file
`define CORE_NREG 32
`define CORE_REG_AW 5

// first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// fetching from here stops the core
`define CORE_HALT_PC 32'h0000_0100

`endif

// File: hdl/core_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [`CORE_XLEN-1:0] imem_addr_o,
    input  logic [`CORE_XLEN-1:0] imem_rdata_i,
    output logic [`CORE_XLEN-1:0] dmem_addr_o,
    output logic [`CORE_XLEN-1:0] dmem_wdata_o,
    output logic                  dmem_wen_o,
    input  logic [`CORE_XLEN-1:0] dmem_rdata_i,
    output logic                  exit_o
);

    core_pkg::alu_op_e       alu_op;
    core_pkg::op1_sel_e      op1_sel;
    core_pkg::op2_sel_e      op2_sel;
    core_pkg::wb_sel_e       wb_sel;
    logic [`CORE_XLEN-1:0]   imm;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    rf_wen;
    logic                    mem_wen;
    logic                    is_branch;
    logic                    is_jump;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic [`CORE_XLEN-1:0]   op1;
    logic [`CORE_XLEN-1:0]   op2;
    logic [`CORE_XLEN-1:0]   alu_result;
    logic                    br_taken;
    logic [`CORE_XLEN-1:0]   wb_data;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   pc_plus4;
    logic                    halted;
    logic                    run;

    assign run = !halted; // no side effects once halted

    decoder u_decoder (
        .inst_i      (imem_rdata_i),
        .alu_op_o    (alu_op),
        .op1_sel_o   (op1_sel),
        .op2_sel_o   (op2_sel),
        .imm_o       (imm),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .rf_wen_o    (rf_wen),
        .mem_wen_o   (mem_wen),
        .is_branch_o (is_branch),
        .is_jump_o   (is_jump),
        .wb_sel_o    (wb_sel)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (rf_wen && run),
        .waddr_i  (rd),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .wdata_i  (wb_data),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    always_comb begin
        case (op1_sel)
            core_pkg::OP1_RS1: op1 = rs1_data;
            core_pkg::OP1_PC:  op1 = pc;
            default:           op1 = '0; // lui
        endcase
    end

    assign op2 = (op2_sel == core_pkg::OP2_IMM) ? imm : rs2_data;

    alu u_alu (
        .op_i       (alu_op),
        .a_i        (op1),
        .b_i        (op2),
        .result_o   (alu_result),
        .br_taken_o (br_taken)
    );

    always_comb begin
        case (wb_sel)
            core_pkg::WB_MEM: wb_data = dmem_rdata_i;
            core_pkg::WB_PC4: wb_data = pc_plus4; // jal/jalr link
            default:          wb_data = alu_result;
        endcase
    end

    pc_unit u_pc_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .br_taken_i    (br_taken && is_branch),
        .is_jump_i     (is_jump),
        .imm_i         (imm),
        .jump_target_i (alu_result),
        .pc_o          (pc),
        .pc_plus4_o    (pc_plus4),
        .halted_o      (halted)
    );

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = mem_wen && run;
    assign exit_o       = halted;

endmodule

// File: hdl/decoder.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module decoder (
    input  logic [`CORE_XLEN-1:0]   inst_i,
    output core_pkg::alu_op_e       alu_op_o,
    output core_pkg::op1_sel_e      op1_sel_o,
    output core_pkg::op2_sel_e      op2_sel_o,
    output logic [`CORE_XLEN-1:0]   imm_o,
    output logic [`CORE_REG_AW-1:0] rs1_o,
    output logic [`CORE_REG_AW-1:0] rs2_o,
    output logic [`CORE_REG_AW-1:0] rd_o,
    output logic                    rf_wen_o,
    output logic                    mem_wen_o,
    output logic                    is_branch_o,
    output logic                    is_jump_o,
    output core_pkg::wb_sel_e       wb_sel_o
);

    core_pkg::inst_u inst;
    logic [2:0]      f3;
    logic            f7_base;
    logic            f7_alt;

    assign inst    = inst_i;
    assign f3      = inst.r.funct3;
    assign f7_base = inst.r.funct7 == core_pkg::F7_BASE;
    assign f7_alt  = inst.r.funct7 == core_pkg::F7_ALT;

    assign rs1_o = inst.r.rs1;
    assign rs2_o = inst.r.rs2;
    assign rd_o  = inst.r.rd;

    // shared by op and op-imm
    function automatic core_pkg::alu_op_e alu_fn(input logic [2:0] fn3, input logic alt);
        case (fn3)
            core_pkg::F3_ADD_SUB: return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            core_pkg::F3_SLL:     return core_pkg::ALU_SLL;
            core_pkg::F3_SLT:     return core_pkg::ALU_SLT;
            core_pkg::F3_SLTU:    return core_pkg::ALU_SLTU;
            core_pkg::F3_XOR:     return core_pkg::ALU_XOR;
            core_pkg::F3_SRL_SRA: return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            core_pkg::F3_OR:      return core_pkg::ALU_OR;
            default:              return core_pkg::ALU_AND;
        endcase
    endfunction

    // immediate of the format the opcode implies
    always_comb begin
        case (inst.r.opcode)
            core_pkg::OPC_LOAD, core_pkg::OPC_OP_IMM, core_pkg::OPC_JALR:
                imm_o = {{(`CORE_XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            core_pkg::OPC_STORE:
                imm_o = {{(`CORE_XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            core_pkg::OPC_BRANCH:
                imm_o = {{(`CORE_XLEN-12){inst.b.imm_12}}, inst.b.imm_11,
                         inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            core_pkg::OPC_LUI, core_pkg::OPC_AUIPC:
                imm_o = {inst.u.imm_31_12, 12'b0};
            core_pkg::OPC_JAL:
                imm_o = {{(`CORE_XLEN-20){inst.j.imm_20}}, inst.j.imm_19_12,
                         inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            default:
                imm_o = '0;
        endcase
    end

    always_comb begin
        alu_op_o    = core_pkg::ALU_ADD;
        op1_sel_o   = core_pkg::OP1_RS1;
        op2_sel_o   = core_pkg::OP2_RS2;
        wb_sel_o    = core_pkg::WB_ALU;
        rf_wen_o    = 1'b0;
        mem_wen_o   = 1'b0;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        case (inst.r.opcode)
            core_pkg::OPC_LOAD: begin
                op2_sel_o = core_pkg::OP2_IMM;
                wb_sel_o  = core_pkg::WB_MEM;
                rf_wen_o  = f3 == core_pkg::F3_LW;
            end
            core_pkg::OPC_STORE: begin
                op2_sel_o = core_pkg::OP2_IMM;
                mem_wen_o = f3 == core_pkg::F3_SW;
            end
            core_pkg::OPC_OP: begin
                alu_op_o = alu_fn(f3, f7_alt);
                rf_wen_o = f7_base || (f7_alt && (f3 == core_pkg::F3_ADD_SUB ||
                                                  f3 == core_pkg::F3_SRL_SRA));
            end
            core_pkg::OPC_OP_IMM: begin
                op2_sel_o = core_pkg::OP2_IMM;
                alu_op_o  = alu_fn(f3, f7_alt && f3 == core_pkg::F3_SRL_SRA);
                if (f3 == core_pkg::F3_SLL)
                    rf_wen_o = f7_base;
                else if (f3 == core_pkg::F3_SRL_SRA)
                    rf_wen_o = f7_base || f7_alt;
                else
                    rf_wen_o = 1'b1;
            end
            core_pkg::OPC_BRANCH: begin
                is_branch_o = 1'b1;
                case (f3)
                    core_pkg::F3_BEQ:  alu_op_o = core_pkg::ALU_BEQ;
                    core_pkg::F3_BNE:  alu_op_o = core_pkg::ALU_BNE;
                    core_pkg::F3_BLT:  alu_op_o = core_pkg::ALU_BLT;
                    core_pkg::F3_BGE:  alu_op_o = core_pkg::ALU_BGE;
                    core_pkg::F3_BLTU: alu_op_o = core_pkg::ALU_BLTU;
                    core_pkg::F3_BGEU: alu_op_o = core_pkg::ALU_BGEU;
                    default:           is_branch_o = 1'b0; // 010/011 reserved
                endcase
            end
            core_pkg::OPC_JAL: begin
                op1_sel_o = core_pkg::OP1_PC;
                op2_sel_o = core_pkg::OP2_IMM;
                wb_sel_o  = core_pkg::WB_PC4;
                rf_wen_o  = 1'b1;
                is_jump_o = 1'b1;
            end
            core_pkg::OPC_JALR: begin
                alu_op_o  = core_pkg::ALU_JALR;
                op2_sel_o = core_pkg::OP2_IMM;
                wb_sel_o  = core_pkg::WB_PC4;
                rf_wen_o  = f3 == core_pkg::F3_JALR;
                is_jump_o = f3 == core_pkg::F3_JALR;
            end
            core_pkg::OPC_LUI: begin
                op1_sel_o = core_pkg::OP1_ZERO;
                op2_sel_o = core_pkg::OP2_IMM;
                rf_wen_o  = 1'b1;
            end
            core_pkg::OPC_AUIPC: begin
                op1_sel_o = core_pkg::OP1_PC;
                op2_sel_o = core_pkg::OP2_IMM;
                rf_wen_o  = 1'b1;
            end
            default: ; // unknown, falls through as a nop
        endcase
    end

endmodule

// File: hdl/pc_unit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module pc_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  br_taken_i,
    input  logic                  is_jump_i,
    input  logic [`CORE_XLEN-1:0] imm_i,
    input  logic [`CORE_XLEN-1:0] jump_target_i,
    output logic [`CORE_XLEN-1:0] pc_o,
    output logic [`CORE_XLEN-1:0] pc_plus4_o,
    output logic                  halted_o
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] pc_next;

    assign pc_plus4_o = pc_q + `CORE_XLEN'd4;

    always_comb begin
        if (br_taken_i)
            pc_next = pc_q + imm_i; // branch offset is pc relative
        else if (is_jump_i)
            pc_next = jump_target_i;
        else
            pc_next = pc_plus4_o;
    end

    assign halted_o = pc_q == `CORE_HALT_PC;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `CORE_RESET_PC;
        end else if (!halted_o) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we_i,
    input  logic [`CORE_REG_AW-1:0] waddr_i,
    input  logic [`CORE_REG_AW-1:0] raddr1_i,
    input  logic [`CORE_REG_AW-1:0] raddr2_i,
    input  logic [`CORE_XLEN-1:0]   wdata_i,
    output logic [`CORE_XLEN-1:0]   rdata1_o,
    output logic [`CORE_XLEN-1:0]   rdata2_o
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREG];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read, new value seen by the next instruction
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/core_sim)"
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi

exit 1

// File: tests/core_checker.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`CORE_XLEN-1:0] imem_addr_i,
    input logic                  dmem_wen_i,
    input logic                  exit_i
);

    // halted core never touches data memory
    a_no_write_halted: assert property (@(posedge clk) disable iff (!rst_n)
        exit_i |-> !dmem_wen_i)
        else $error("data memory write while the core is halted");

    a_exit_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        exit_i |=> exit_i)
        else $error("exit_o dropped without a reset");

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr_i[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // first fetch after reset
    a_reset_pc: assert property (@(posedge clk)
        !rst_n |=> imem_addr_i == `CORE_RESET_PC)
        else $error("fetch address after reset is not the reset vector");

endmodule

bind core_top core_checker i_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr_i (imem_addr_o),
    .dmem_wen_i  (dmem_wen_o),
    .exit_i      (exit_o)
);

// File: tests/core_stim.txt
// word count, program words, check count, then pairs of byte address and expected word
// program runs from 0x000, skips the halt slot at 0x100 and jumps back to it at the end
00000057
20000093 00500113 FFD00193 003102B3 40310333 003173B3 00316433 003145B3
00219633 0021D6B3 4021D733 0021A7B3 0021B833 FF910893 00F1F913 03016993
FFF1CA13 00411A93 01C1DB13 4011DB93 FFE1AC13 00413C93 00710013 0050A023
0060A223 0070A423 0080A623 00B0A823 00C0AA23 00D0AC23 00E0AE23 02F0A023
0300A223 0310A423 0320A623 0330A823 0340AA23 0350AC23 0360AE23 0570A023
0580A223 0590A423 0400A623 00210463 0014E493 00310463 0024E493 00311463
0044E493 00211463 0084E493 0021C463 0104E493 00314463 0204E493 00315463
001D6D13 0021D463 002D6D13 00316463 004D6D13 0021E463 008D6D13 0080006F
00000013 0021F463 010D6D13 00317463 020D6D13 0490A823 05A0AA23 00800DEF
00000D93 00000E97 00CE8E67 00000E13 00001F17 12345FB7 0000A503 06450513
05B0AC23 05C0AE23 07D0A023 07E0A223 07F0A423 06A0A623 FA9FF06F
0000001C
00000200 00000002  00000204 00000008
00000208 00000005  0000020C FFFFFFFD
00000210 FFFFFFF8  00000214 FFFFFFA0
00000218 07FFFFFF  0000021C FFFFFFFF
00000220 00000001  00000224 00000000
00000228 FFFFFFFE  0000022C 0000000D
00000230 00000035  00000234 00000002
00000238 00000050  0000023C 0000000F
00000240 FFFFFFFE  00000244 00000001
00000248 00000000  0000024C 00000000
00000250 0000002A  00000254 0000002A
00000258 00000120  0000025C 0000012C
00000260 00000124  00000264 00001130
00000268 12345000  0000026C 00000066

// File: tests/core_tb.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;

    localparam int ROM_WORDS  = 256;
    localparam int RAM_WORDS  = 1024;
    localparam int STIM_WORDS = 512;
    localparam int RUN_LIMIT  = 2000;
    localparam int HALT_HOLD  = 10;

    logic                  clk;
    logic                  rst_n;
    logic [`CORE_XLEN-1:0] imem_addr;
    logic [`CORE_XLEN-1:0] imem_rdata;
    logic [`CORE_XLEN-1:0] dmem_addr;
    logic [`CORE_XLEN-1:0] dmem_wdata;
    logic                  dmem_wen;
    logic [`CORE_XLEN-1:0] dmem_rdata;
    logic                  exit_flag;

    logic [31:0] rom      [ROM_WORDS];
    logic [31:0] ram      [RAM_WORDS];
    logic [31:0] ram_snap [RAM_WORDS];
    logic [31:0] stim     [STIM_WORDS];

    int errors;
    int tests_run;
    int tests_failed;
    int n_prog;
    int n_chk;
    bit timed_out;

    core_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_wen_o   (dmem_wen),
        .dmem_rdata_i (dmem_rdata),
        .exit_o       (exit_flag)
    );

    always #20 clk = ~clk;

    // memories answer in the same cycle
    assign imem_rdata = rom[imem_addr[9:2]];
    assign dmem_rdata = ram[dmem_addr[11:2]];

    always @(posedge clk) begin
        if (dmem_wen)
            ram[dmem_addr[11:2]] <= dmem_wdata;
    end

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("[%0s] ok", name);
        end else begin
            tests_failed++;
            $display("[%0s] FAILED", name);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < STIM_WORDS; i++)
            stim[i] = '0;
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = 32'h0000_0013; // nop
        for (int i = 0; i < RAM_WORDS; i++)
            ram[i] = 32'hc0de_0000 ^ i;
        $readmemh("tests/core_stim.txt", stim);
        n_prog = int'(stim[0]);
        if (n_prog > ROM_WORDS)
            n_prog = ROM_WORDS;
        for (int i = 0; i < n_prog; i++)
            rom[i] = stim[1 + i];
        // store in the halt slot, fetched but never allowed to write
        rom[`CORE_HALT_PC >> 2] = 32'h0020_a023; // sw x2, 0(x1)
        n_chk = int'(stim[1 + n_prog]);
        if (2 + n_prog + 2 * n_chk > STIM_WORDS)
            n_chk = 0;
    endtask

    task automatic check_reset();
        int e0;
        e0 = errors;
        assert (imem_addr == `CORE_RESET_PC) else begin
            $display("Mismatch imem_addr_o: got 0x%08h expected 0x%08h",
                     imem_addr, `CORE_RESET_PC);
            errors++;
        end
        assert (!exit_flag) else begin
            $display("Mismatch exit_o: got 0x%0h expected 0x0", exit_flag);
            errors++;
        end
        assert (!dmem_wen) else begin
            $display("Mismatch dmem_wen_o: got 0x%0h expected 0x0", dmem_wen);
            errors++;
        end
        end_test("reset", e0);
    endtask

    task automatic run_to_exit();
        int e0;
        int cyc;
        e0 = errors;
        cyc = 0;
        while (!exit_flag && cyc < RUN_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (!exit_flag) begin
            $display("timeout: exit_o did not rise within %0d cycles", RUN_LIMIT);
            errors++;
            timed_out = 1'b1;
        end
        end_test("run to halt", e0);
    endtask

    task automatic check_results();
        logic [31:0] addr;
        logic [31:0] exp;
        logic [31:0] got;
        int e0;
        for (int k = 0; k < n_chk; k++) begin
            e0 = errors;
            addr = stim[2 + n_prog + 2 * k];
            exp = stim[3 + n_prog + 2 * k];
            got = ram[addr[11:2]];
            assert (got === exp) else begin
                $display("Mismatch dmem[0x%08h]: got 0x%08h expected 0x%08h", addr, got, exp);
                errors++;
            end
            end_test($sformatf("dmem 0x%08h", addr), e0);
        end
    endtask

    task automatic check_halt_hold();
        int e0;
        e0 = errors;
        for (int i = 0; i < RAM_WORDS; i++)
            ram_snap[i] = ram[i];
        for (int c = 0; c < HALT_HOLD; c++) begin
            @(negedge clk);
            assert (imem_addr == `CORE_HALT_PC) else begin
                $display("Mismatch imem_addr_o: got 0x%08h expected 0x%08h",
                         imem_addr, `CORE_HALT_PC);
                errors++;
            end
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            assert (ram[i] === ram_snap[i]) else begin
                $display("Mismatch dmem[0x%08h]: got 0x%08h expected 0x%08h",
                         i * 4, ram[i], ram_snap[i]);
                errors++;
            end
        end
        end_test("halt hold", e0);
    endtask

    initial begin
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        clk = 1'b0;
        rst_n = 1'b0;
        void'($urandom(53952));
        load_program();

        // two reset edges, state checked between them
        @(posedge clk);
        @(negedge clk);
        check_reset();
        @(posedge clk);
        #2 rst_n = 1'b1;

        run_to_exit();
        if (!timed_out) begin
            check_results();
            check_halt_hold();
        end

        $display("%0d tests, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
